//--- include/fabric_consts.svh
// Fabric constants: address map, bus widths, timer offsets and RAM latency
`ifndef FABRIC_CONSTS_SVH
`define FABRIC_CONSTS_SVH

// Bus widths
`define FABRIC_ADDR_W 32
`define FABRIC_DATA_W 32
`define FABRIC_SEL_W 4

// Cache line of four words, 256 lines for 4 KiB
`define FABRIC_LINE_W 128
`define FABRIC_RAM_LINES 256

// Top address nibble of each region
`define FABRIC_RAM_REGION 4'h8
`define FABRIC_CLINT_REGION 4'h3

// Timer block register offsets, low 16 address bits
`define FABRIC_CLINT_MSIP 16'h0000
`define FABRIC_CLINT_MTIMECMP_LO 16'h4000
`define FABRIC_CLINT_MTIMECMP_HI 16'h4004
`define FABRIC_CLINT_MTIME_LO 16'hBFF8
`define FABRIC_CLINT_MTIME_HI 16'hBFFC

// First read beat latency in cycles
`define FABRIC_RAM_LATENCY 4

`endif

//--- src/fabric_pkg.sv
// Fabric package with the bus cycle types, target classes and line types
`include "fabric_consts.svh"

package fabric_pkg;

  // ====================================================================
  // Wishbone B4 cycle type identifier
  // ====================================================================
  // Only the three kinds the fabric understands
  typedef enum logic [2:0] {
    CTI_CLASSIC = 3'b000,
    CTI_INCR    = 3'b010,
    CTI_EOB     = 3'b111
  } wb_cti_e;

  // ====================================================================
  // Decoded target of a request
  // ====================================================================
  // Unmapped also covers the old peripheral region
  typedef enum logic [1:0] {
    TGT_RAM,
    TGT_CLINT,
    TGT_UNMAPPED
  } wb_target_e;

  // ====================================================================
  // Cache line types
  // ====================================================================
  // Whole line, four words
  typedef logic [`FABRIC_LINE_W-1:0] line_t;

  // One strobe per byte of the line
  typedef logic [`FABRIC_LINE_W/8-1:0] line_strb_t;

endpackage

//--- src/wb_req_decoder.sv
// Request stage: accepts one Wishbone beat, decodes its target, stalls until the reply
`timescale 1ns/10ps
`include "fabric_consts.svh"

module wb_req_decoder
  import fabric_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Bus side
  input  logic                      wb_cyc_i,
  input  logic                      wb_stb_i,
  input  logic                      wb_we_i,
  input  logic [`FABRIC_ADDR_W-1:0] wb_adr_i,
  input  logic [`FABRIC_DATA_W-1:0] wb_dat_i,
  input  logic [`FABRIC_SEL_W-1:0]  wb_sel_i,
  input  wb_cti_e                   wb_cti_i,
  input  logic                      rsp_done_i,
  output logic                      wb_stall_o,
  // Target side
  output logic                      ram_req_o,
  output logic                      clint_req_o,
  output logic                      unmapped_req_o,
  output logic                      req_we_o,
  output logic [`FABRIC_ADDR_W-1:0] req_adr_o,
  output logic [`FABRIC_DATA_W-1:0] req_dat_o,
  output logic [`FABRIC_SEL_W-1:0]  req_sel_o,
  output wb_cti_e                   req_cti_o
);

  logic       accept;
  logic       busy_q;
  wb_target_e target_d;

  // Beat taken when strobed and not stalled
  assign accept = wb_cyc_i && wb_stb_i && !busy_q;

  // Region from top address nibble
  always_comb begin
    case (wb_adr_i[`FABRIC_ADDR_W-1 -: 4])
      `FABRIC_RAM_REGION:   target_d = TGT_RAM;
      `FABRIC_CLINT_REGION: target_d = TGT_CLINT;
      default:              target_d = TGT_UNMAPPED;
    endcase
  end

  // ====================================================================
  // Busy flag and request pulses
  // ====================================================================
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q         <= 1'b0;
      ram_req_o      <= 1'b0;
      clint_req_o    <= 1'b0;
      unmapped_req_o <= 1'b0;
    end else begin
      // One-cycle pulse to the selected target
      ram_req_o      <= accept && (target_d == TGT_RAM);
      clint_req_o    <= accept && (target_d == TGT_CLINT);
      unmapped_req_o <= accept && (target_d == TGT_UNMAPPED);
      if (accept) begin
        busy_q <= 1'b1;
      end else if (rsp_done_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Request fields held until the next accepted beat
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_we_o  <= wb_we_i;
      req_adr_o <= wb_adr_i;
      req_dat_o <= wb_dat_i;
      req_sel_o <= wb_sel_i;
      req_cti_o <= wb_cti_i;
    end
  end

  assign wb_stall_o = busy_q;

  // A response only comes back for a beat in flight
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_done_i |-> busy_q);

endmodule

//--- src/line_ram.sv
// Line RAM: cache-line storage with byte-strobe writes and a registered read port
`timescale 1ns/10ps
`include "fabric_consts.svh"

module line_ram
  import fabric_pkg::*;
(
  input  logic                                clk_i,
  input  logic [$clog2(`FABRIC_RAM_LINES)-1:0] addr_i,
  input  line_t                               wdata_i,
  input  line_strb_t                          wstrb_i,
  input  logic                                rd_en_i,
  output line_t                               rdata_o
);

  localparam int unsigned LINE_BYTES = `FABRIC_LINE_W / 8;

  // Storage array, one entry per line
  line_t mem_q [`FABRIC_RAM_LINES];
  line_t rdata_q;

  // ====================================================================
  // Write and read ports
  // ====================================================================
  always_ff @(posedge clk_i) begin
    // Per-byte write enables
    for (int b = 0; b < LINE_BYTES; b++) begin
      if (wstrb_i[b]) begin
        mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
      end
    end
    // Read data held until the next read
    if (rd_en_i) begin
      rdata_q <= mem_q[addr_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

//--- src/line_ram_adapter.sv
// RAM adapter: expands word writes to lines, delays first reads, serves bursts from a buffer
`timescale 1ns/10ps
`include "fabric_consts.svh"

module line_ram_adapter
  import fabric_pkg::*;
#(
  // Cycles from ram_req to ack on a buffer miss, at least 2
  parameter int unsigned RAM_LATENCY = `FABRIC_RAM_LATENCY
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      ram_req_i,
  input  logic                      req_we_i,
  input  logic [`FABRIC_ADDR_W-1:0] req_adr_i,
  input  logic [`FABRIC_DATA_W-1:0] req_dat_i,
  input  logic [`FABRIC_SEL_W-1:0]  req_sel_i,
  input  wb_cti_e                   req_cti_i,
  output logic                      ram_ack_o,
  output logic [`FABRIC_DATA_W-1:0] ram_rdata_o
);

  localparam int unsigned WORDS = `FABRIC_LINE_W / `FABRIC_DATA_W;
  localparam int unsigned OFF_W = $clog2(WORDS);
  localparam int unsigned IDX_W = $clog2(`FABRIC_RAM_LINES);

  logic [OFF_W-1:0]       word_off;
  logic [IDX_W-1:0]       line_idx;
  line_t                  wdata_line;
  line_strb_t             wstrb_line;
  line_t                  rdata_line;
  logic                   buf_hit;
  logic                   rd_en;
  logic [RAM_LATENCY-1:0] delay_q;
  logic                   wr_ack_q;
  logic                   hit_ack_q;
  logic                   buf_valid_q;
  line_t                  buf_q;
  logic [IDX_W-1:0]       buf_line_q;

  // Word within the line, then line index
  assign word_off = req_adr_i[2 +: OFF_W];
  assign line_idx = req_adr_i[2+OFF_W +: IDX_W];

  // ====================================================================
  // Write expansion
  // ====================================================================
  // Word copied to every slot, strobes pick the slot
  always_comb begin
    wdata_line = {WORDS{req_dat_i}};
    wstrb_line = '0;
    if (ram_req_i && req_we_i) begin
      wstrb_line[word_off*`FABRIC_SEL_W +: `FABRIC_SEL_W] = req_sel_i;
    end
  end

  // Burst beats after the first come from the buffer
  assign buf_hit = buf_valid_q && (req_cti_i != CTI_CLASSIC);
  assign rd_en   = ram_req_i && !req_we_i && !buf_hit;

  line_ram i_line_ram (
    .clk_i  (clk_i),
    .addr_i (line_idx),
    .wdata_i(wdata_line),
    .wstrb_i(wstrb_line),
    .rd_en_i(rd_en),
    .rdata_o(rdata_line)
  );

  // ====================================================================
  // Latency pipeline and line buffer
  // ====================================================================
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      delay_q     <= '0;
      wr_ack_q    <= 1'b0;
      hit_ack_q   <= 1'b0;
      buf_valid_q <= 1'b0;
    end else begin
      // Miss travels RAM_LATENCY stages before its ack
      delay_q   <= {delay_q[RAM_LATENCY-2:0], rd_en};
      wr_ack_q  <= ram_req_i && req_we_i;
      hit_ack_q <= ram_req_i && !req_we_i && buf_hit;
      // Buffer kept only for the first beat of an incrementing burst
      if (delay_q[RAM_LATENCY-1]) begin
        buf_valid_q <= (req_cti_i == CTI_INCR);
      end else if (ram_req_i && buf_hit && (req_cti_i == CTI_EOB)) begin
        buf_valid_q <= 1'b0;
      end
    end
  end

  // Line captured as the first beat is acknowledged
  always_ff @(posedge clk_i) begin
    if (delay_q[RAM_LATENCY-1]) begin
      buf_q      <= rdata_line;
      buf_line_q <= line_idx;
    end
  end

  assign ram_ack_o   = wr_ack_q || hit_ack_q || delay_q[RAM_LATENCY-1];
  assign ram_rdata_o = delay_q[RAM_LATENCY-1] ?
                       rdata_line[word_off*`FABRIC_DATA_W +: `FABRIC_DATA_W] :
                       buf_q[word_off*`FABRIC_DATA_W +: `FABRIC_DATA_W];

  // Burst beats must stay inside the buffered line
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    hit_ack_q |-> (line_idx == buf_line_q));

endmodule

//--- src/clint_timer.sv
// Core-local timer: free-running mtime, mtimecmp, msip and the two interrupt lines
`timescale 1ns/10ps
`include "fabric_consts.svh"

module clint_timer (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      clint_req_i,
  input  logic                      req_we_i,
  input  logic [`FABRIC_ADDR_W-1:0] req_adr_i,
  input  logic [`FABRIC_DATA_W-1:0] req_dat_i,
  input  logic [`FABRIC_SEL_W-1:0]  req_sel_i,
  output logic                      clint_ack_o,
  output logic [`FABRIC_DATA_W-1:0] clint_rdata_o,
  output logic                      timer_irq_o,
  output logic                      sw_irq_o
);

  localparam int unsigned DW = `FABRIC_DATA_W;

  logic [15:0]   offset;
  logic [63:0]   mtime_q;
  logic [63:0]   mtimecmp_q;
  logic          msip_q;
  logic          wr_en;
  logic [DW-1:0] rdata_d;

  // Byte-select merge of a write into a register half
  function automatic logic [DW-1:0] merge_bytes(input logic [DW-1:0] old_w,
                                                input logic [DW-1:0] new_w,
                                                input logic [`FABRIC_SEL_W-1:0] sel);
    logic [DW-1:0] res;
    res = old_w;
    for (int b = 0; b < `FABRIC_SEL_W; b++) begin
      if (sel[b]) res[b*8 +: 8] = new_w[b*8 +: 8];
    end
    return res;
  endfunction

  assign offset = req_adr_i[15:0];
  assign wr_en  = clint_req_i && req_we_i;

  // ====================================================================
  // Registers
  // ====================================================================
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mtime_q     <= '0;
      mtimecmp_q  <= '1;
      msip_q      <= 1'b0;
      clint_ack_o <= 1'b0;
    end else begin
      mtime_q     <= mtime_q + 64'd1;
      clint_ack_o <= clint_req_i;
      // mtime offsets are read only
      if (wr_en && (offset == `FABRIC_CLINT_MSIP) && req_sel_i[0]) msip_q <= req_dat_i[0];
      if (wr_en && (offset == `FABRIC_CLINT_MTIMECMP_LO)) begin
        mtimecmp_q[31:0] <= merge_bytes(mtimecmp_q[31:0], req_dat_i, req_sel_i);
      end
      if (wr_en && (offset == `FABRIC_CLINT_MTIMECMP_HI)) begin
        mtimecmp_q[63:32] <= merge_bytes(mtimecmp_q[63:32], req_dat_i, req_sel_i);
      end
    end
  end

  // Read mux, zero for any other offset
  always_comb begin
    case (offset)
      `FABRIC_CLINT_MSIP:        rdata_d = {{(DW-1){1'b0}}, msip_q};
      `FABRIC_CLINT_MTIMECMP_LO: rdata_d = mtimecmp_q[31:0];
      `FABRIC_CLINT_MTIMECMP_HI: rdata_d = mtimecmp_q[63:32];
      `FABRIC_CLINT_MTIME_LO:    rdata_d = mtime_q[31:0];
      `FABRIC_CLINT_MTIME_HI:    rdata_d = mtime_q[63:32];
      default:                   rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (clint_req_i) clint_rdata_o <= rdata_d;
  end

  // Interrupts
  assign timer_irq_o = (mtime_q >= mtimecmp_q);
  assign sw_irq_o    = msip_q;

endmodule

//--- src/wb_resp_mux.sv
// Response stage: registers the answering target's reply or a decode error onto the bus
`timescale 1ns/10ps
`include "fabric_consts.svh"

module wb_resp_mux (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      ram_ack_i,
  input  logic [`FABRIC_DATA_W-1:0] ram_rdata_i,
  input  logic                      clint_ack_i,
  input  logic [`FABRIC_DATA_W-1:0] clint_rdata_i,
  input  logic                      unmapped_req_i,
  output logic                      wb_ack_o,
  output logic                      wb_err_o,
  output logic [`FABRIC_DATA_W-1:0] wb_dat_o,
  output logic                      rsp_done_o
);

  // ====================================================================
  // Response registers
  // ====================================================================
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_ack_o <= 1'b0;
      wb_err_o <= 1'b0;
    end else begin
      wb_ack_o <= ram_ack_i || clint_ack_i;
      // Decode miss answered directly as error
      wb_err_o <= unmapped_req_i;
    end
  end

  // Data of whichever target answered, zero on error
  always_ff @(posedge clk_i) begin
    if (ram_ack_i) wb_dat_o <= ram_rdata_i;
    else if (clint_ack_i) wb_dat_o <= clint_rdata_i;
    else if (unmapped_req_i) wb_dat_o <= '0;
  end

  // Frees the request stage for the next beat
  assign rsp_done_o = wb_ack_o || wb_err_o;

  // Targets never answer in the same cycle
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0({ram_ack_i, clint_ack_i, unmapped_req_i}));

endmodule

//--- src/wb_soc_fabric.sv
// Fabric top: request decoder, RAM adapter, timer block and response mux on one Wishbone port
`timescale 1ns/10ps
`include "fabric_consts.svh"

module wb_soc_fabric
  import fabric_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Wishbone B4 slave port
  input  logic                      wb_cyc_i,
  input  logic                      wb_stb_i,
  input  logic                      wb_we_i,
  input  logic [`FABRIC_ADDR_W-1:0] wb_adr_i,
  input  logic [`FABRIC_DATA_W-1:0] wb_dat_i,
  input  logic [`FABRIC_SEL_W-1:0]  wb_sel_i,
  input  wb_cti_e                   wb_cti_i,
  output logic [`FABRIC_DATA_W-1:0] wb_dat_o,
  output logic                      wb_ack_o,
  output logic                      wb_err_o,
  output logic                      wb_stall_o,
  // Interrupts
  output logic                      timer_irq_o,
  output logic                      sw_irq_o
);

  logic                      ram_req, clint_req, unmapped_req;
  logic                      req_we;
  logic [`FABRIC_ADDR_W-1:0] req_adr;
  logic [`FABRIC_DATA_W-1:0] req_dat;
  logic [`FABRIC_SEL_W-1:0]  req_sel;
  wb_cti_e                   req_cti;
  logic                      ram_ack, clint_ack, rsp_done;
  logic [`FABRIC_DATA_W-1:0] ram_rdata, clint_rdata;

  // ====================================================================
  // Request stage
  // ====================================================================
  wb_req_decoder i_req_decoder (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i), .wb_adr_i(wb_adr_i),
    .wb_dat_i(wb_dat_i), .wb_sel_i(wb_sel_i), .wb_cti_i(wb_cti_i),
    .rsp_done_i(rsp_done), .wb_stall_o(wb_stall_o),
    .ram_req_o(ram_req), .clint_req_o(clint_req), .unmapped_req_o(unmapped_req),
    .req_we_o(req_we), .req_adr_o(req_adr), .req_dat_o(req_dat),
    .req_sel_o(req_sel), .req_cti_o(req_cti)
  );

  // ====================================================================
  // Targets
  // ====================================================================
  line_ram_adapter #(.RAM_LATENCY(`FABRIC_RAM_LATENCY)) i_ram_adapter (
    .clk_i(clk_i), .rst_ni(rst_ni), .ram_req_i(ram_req), .req_we_i(req_we),
    .req_adr_i(req_adr), .req_dat_i(req_dat), .req_sel_i(req_sel), .req_cti_i(req_cti),
    .ram_ack_o(ram_ack), .ram_rdata_o(ram_rdata)
  );

  clint_timer i_clint (
    .clk_i(clk_i), .rst_ni(rst_ni), .clint_req_i(clint_req), .req_we_i(req_we),
    .req_adr_i(req_adr), .req_dat_i(req_dat), .req_sel_i(req_sel),
    .clint_ack_o(clint_ack), .clint_rdata_o(clint_rdata),
    .timer_irq_o(timer_irq_o), .sw_irq_o(sw_irq_o)
  );

  // Response stage
  wb_resp_mux i_resp_mux (
    .clk_i(clk_i), .rst_ni(rst_ni), .ram_ack_i(ram_ack), .ram_rdata_i(ram_rdata),
    .clint_ack_i(clint_ack), .clint_rdata_i(clint_rdata), .unmapped_req_i(unmapped_req),
    .wb_ack_o(wb_ack_o), .wb_err_o(wb_err_o), .wb_dat_o(wb_dat_o), .rsp_done_o(rsp_done)
  );

endmodule

//--- dv/tb_wb_soc_fabric.sv
// Testbench for the Wishbone fabric with a bus master, a reference RAM model and response checks
`timescale 1ns/10ps
`include "fabric_consts.svh"

module tb_wb_soc_fabric
  import fabric_pkg::*;
();

  localparam int INIT_WORDS  = 64;
  localparam int N_RAND      = 40;
  localparam int BURST_LINES = 4;
  // Beats per phase: init, random, bursts, buffer clear, unmapped, timer with its wait
  localparam int NUM_BEATS = INIT_WORDS + 2*N_RAND + 6*BURST_LINES + 10 + 6 + 20;

  logic                      clk_i;
  logic                      rst_ni;
  logic                      wb_cyc_i;
  logic                      wb_stb_i;
  logic                      wb_we_i;
  logic [`FABRIC_ADDR_W-1:0] wb_adr_i;
  logic [`FABRIC_DATA_W-1:0] wb_dat_i;
  logic [`FABRIC_SEL_W-1:0]  wb_sel_i;
  wb_cti_e                   wb_cti_i;
  logic [`FABRIC_DATA_W-1:0] wb_dat_o;
  logic                      wb_ack_o;
  logic                      wb_err_o;
  logic                      wb_stall_o;
  logic                      timer_irq_o;
  logic                      sw_irq_o;

  integer seed = 16570;
  // Word model of the 4 KiB RAM
  logic [`FABRIC_DATA_W-1:0] ref_mem [1024];

  // Expected and observed responses, in beat order
  bit                        exp_err_q [$];
  bit                        exp_chk_q [$];
  logic [`FABRIC_DATA_W-1:0] exp_dat_q [$];
  logic                      act_ack_q [$];
  logic                      act_err_q [$];
  logic [`FABRIC_DATA_W-1:0] act_dat_q [$];

  wb_soc_fabric wb_soc_fabric_i (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i), .wb_adr_i(wb_adr_i),
    .wb_dat_i(wb_dat_i), .wb_sel_i(wb_sel_i), .wb_cti_i(wb_cti_i),
    .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o), .wb_err_o(wb_err_o), .wb_stall_o(wb_stall_o),
    .timer_irq_o(timer_irq_o), .sw_irq_o(sw_irq_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "stopping at first failure");
  endtask

  initial begin
    repeat (NUM_BEATS * 64) @(posedge clk_i);
    report_failure("Watchdog expired before all tests finished");
  end

  // ====================================================================
  // Compare tasks
  // ====================================================================
  task automatic check_word(input string name, input logic [`FABRIC_DATA_W-1:0] exp,
                            input logic [`FABRIC_DATA_W-1:0] got);
    if (got !== exp) report_failure($sformatf("Error: %s expected 0x%h got 0x%h", name, exp, got));
  endtask

  task automatic check_resp(input bit exp_err, input logic got_ack, input logic got_err);
    if (got_ack && got_err) begin
      report_failure("Ack and err were both raised for one beat");
    end else if (got_err !== exp_err) begin
      report_failure($sformatf("Error: wb_err_o expected 0x%h got 0x%h", exp_err, got_err));
    end else if (got_ack !== !exp_err) begin
      report_failure($sformatf("Error: wb_ack_o expected 0x%h got 0x%h", !exp_err, got_ack));
    end
  endtask

  task automatic check_irq(input string name, input logic exp, input logic got);
    if (got !== exp) report_failure($sformatf("Error: %s expected 0x%h got 0x%h", name, exp, got));
  endtask

  // Bus handshake flags, stall and the response strobes
  task automatic check_flag(input string name, input logic exp, input logic got);
    if (got !== exp) begin
      report_failure($sformatf("Error: %s expected 0x%h got 0x%h", name, exp, got));
    end
  endtask

  // ====================================================================
  // Reference model
  // ====================================================================
  // Byte-enabled write, RAM aliases every 4 KiB
  function automatic void ref_write(input logic [31:0] adr, input logic [31:0] dat,
                                    input logic [3:0] sel);
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) ref_mem[adr[11:2]][b*8 +: 8] = dat[b*8 +: 8];
    end
  endfunction

  // Target by top nibble, expected read word for RAM, zero elsewhere
  function automatic logic [31:0] ref_read(input logic [31:0] adr, output wb_target_e tgt);
    case (adr[31:28])
      `FABRIC_RAM_REGION:   tgt = TGT_RAM;
      `FABRIC_CLINT_REGION: tgt = TGT_CLINT;
      default:              tgt = TGT_UNMAPPED;
    endcase
    if (tgt == TGT_RAM) return ref_mem[adr[11:2]];
    return '0;
  endfunction

  // ====================================================================
  // Bus master
  // ====================================================================
  // Waits out stall, holds the beat until ack or err
  task automatic bus_access(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel, input wb_cti_e cti,
                            output logic [31:0] rdata, output logic ack, output logic err);
    @(posedge clk_i);
    #1;
    // Previous response was a single-cycle pulse
    check_flag("wb_ack_o", 1'b0, wb_ack_o);
    check_flag("wb_err_o", 1'b0, wb_err_o);
    while (wb_stall_o) begin
      @(posedge clk_i);
      #1;
    end
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = dat;
    wb_sel_i = sel;
    wb_cti_i = cti;
    @(posedge clk_i);
    #1;
    // Stall high from acceptance through the response cycle
    check_flag("wb_stall_o", 1'b1, wb_stall_o);
    while (!(wb_ack_o || wb_err_o)) begin
      @(posedge clk_i);
      #1;
      check_flag("wb_stall_o", 1'b1, wb_stall_o);
    end
    rdata = wb_dat_o;
    ack   = wb_ack_o;
    err   = wb_err_o;
    wb_stb_i = 1'b0;
    // Cycle stays open between beats of a burst
    wb_cyc_i = (cti == CTI_INCR);
  endtask

  // One beat with its expectation queued for the compare process
  task automatic run_beat(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                          input logic [3:0] sel, input wb_cti_e cti, input bit chk,
                          input logic [31:0] clint_exp, output logic [31:0] rdata);
    wb_target_e tgt;
    logic [31:0] exp;
    logic        ack;
    logic        err;
    exp = ref_read(adr, tgt);
    if (tgt == TGT_CLINT) exp = clint_exp;
    if (we && tgt == TGT_RAM) ref_write(adr, dat, sel);
    exp_err_q.push_back(tgt == TGT_UNMAPPED);
    exp_chk_q.push_back((chk && !we) || tgt == TGT_UNMAPPED);
    exp_dat_q.push_back(exp);
    bus_access(we, adr, dat, sel, cti, rdata, ack, err);
    act_ack_q.push_back(ack);
    act_err_q.push_back(err);
    act_dat_q.push_back(rdata);
  endtask

  // Four incrementing beats, the last marked end of burst
  task automatic burst_read_line(input logic [31:0] base);
    logic [31:0] rdata;
    for (int w = 0; w < 4; w++) begin
      run_beat(1'b0, base + 4*w, '0, 4'hF, (w == 3) ? CTI_EOB : CTI_INCR, 1'b1, '0, rdata);
    end
  endtask

  task automatic wait_timer_irq(input int max_cycles);
    logic seen;
    seen = 1'b0;
    for (int c = 0; c < max_cycles && !seen; c++) begin
      @(posedge clk_i);
      #1;
      seen = timer_irq_o;
    end
    if (!seen) report_failure("Timer interrupt did not rise within the allowed cycles");
  endtask

  // Pops each response and compares it with its expectation
  initial begin : compare_responses
    bit          e_err;
    bit          e_chk;
    logic [31:0] e_dat;
    logic [31:0] a_dat;
    forever begin
      @(posedge clk_i);
      while (act_ack_q.size() > 0) begin
        e_err = exp_err_q.pop_front();
        e_chk = exp_chk_q.pop_front();
        e_dat = exp_dat_q.pop_front();
        a_dat = act_dat_q.pop_front();
        check_resp(e_err, act_ack_q.pop_front(), act_err_q.pop_front());
        // Write acks carry no defined data
        if (e_chk) begin
          check_word("wb_dat_o", e_dat, a_dat);
        end
      end
    end
  end

  // ====================================================================
  // Stimulus
  // ====================================================================
  initial begin
    logic [31:0] rnd;
    logic [31:0] adr;
    logic [31:0] dat;
    logic [31:0] rdata;
    logic [31:0] t0;
    logic [31:0] t1;
    logic [31:0] hi;
    logic [63:0] cmp;
    rst_ni   = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    wb_sel_i = '0;
    wb_cti_i = CTI_CLASSIC;
    repeat (3) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    // Quiet outputs after reset
    check_flag("wb_stall_o", 1'b0, wb_stall_o);
    check_irq("timer_irq_o", 1'b0, timer_irq_o);
    check_irq("sw_irq_o", 1'b0, sw_irq_o);

    // Known contents in the first 64 words
    for (int i = 0; i < INIT_WORDS; i++) begin
      dat = $random(seed);
      run_beat(1'b1, 32'h8000_0000 + 4*i, dat, 4'hF, CTI_CLASSIC, 1'b0, '0, rdata);
    end

    // Random masked writes into the known words, read back through an alias
    for (int i = 0; i < N_RAND; i++) begin
      rnd = $random(seed);
      dat = $random(seed);
      adr = {`FABRIC_RAM_REGION, rnd[31:16], 4'h0, rnd[5:0], 2'b00};
      run_beat(1'b1, adr, dat, rnd[9:6], CTI_CLASSIC, 1'b0, '0, rdata);
      adr[27:12] = ~adr[27:12];
      run_beat(1'b0, adr, '0, 4'hF, CTI_CLASSIC, 1'b1, '0, rdata);
    end

    // Line read, fresh write into it, then a full burst
    for (int l = 0; l < BURST_LINES; l++) begin
      adr = 32'h8000_0000 + 16*l;
      dat = $random(seed);
      run_beat(1'b0, adr, '0, 4'hF, CTI_CLASSIC, 1'b1, '0, rdata);
      run_beat(1'b1, adr + 8, dat, 4'hF, CTI_CLASSIC, 1'b0, '0, rdata);
      burst_read_line(adr);
    end

    // End of burst drops the buffer, new data must show
    burst_read_line(32'h8000_0050);
    run_beat(1'b1, 32'h8000_0054, 32'hA5C3_0F96, 4'hF, CTI_CLASSIC, 1'b0, '0, rdata);
    run_beat(1'b0, 32'h8000_0054, '0, 4'hF, CTI_CLASSIC, 1'b1, '0, rdata);
    burst_read_line(32'h8000_0050);

    // Unmapped regions, old peripheral space included
    run_beat(1'b0, 32'h2000_0100, '0, 4'hF, CTI_CLASSIC, 1'b1, '0, rdata);
    run_beat(1'b1, 32'h2000_0104, 32'h1111_2222, 4'hF, CTI_CLASSIC, 1'b1, '0, rdata);
    run_beat(1'b0, 32'h0000_0000, '0, 4'hF, CTI_CLASSIC, 1'b1, '0, rdata);
    run_beat(1'b0, 32'h1234_5678, '0, 4'hF, CTI_CLASSIC, 1'b1, '0, rdata);
    run_beat(1'b1, 32'hF000_0010, 32'h3333_4444, 4'h3, CTI_CLASSIC, 1'b1, '0, rdata);
    run_beat(1'b0, 32'h4000_0000, '0, 4'hF, CTI_CLASSIC, 1'b1, '0, rdata);

    // Software interrupt follows msip bit 0
    run_beat(1'b1, 32'h3000_0000, 32'h1, 4'hF, CTI_CLASSIC, 1'b0, '0, rdata);
    check_irq("sw_irq_o", 1'b1, sw_irq_o);
    run_beat(1'b1, 32'h3000_0000, 32'h0, 4'hF, CTI_CLASSIC, 1'b0, '0, rdata);
    check_irq("sw_irq_o", 1'b0, sw_irq_o);

    // mtime keeps counting
    run_beat(1'b0, 32'h3000_BFF8, '0, 4'hF, CTI_CLASSIC, 1'b0, '0, t0);
    run_beat(1'b0, 32'h3000_BFF8, '0, 4'hF, CTI_CLASSIC, 1'b0, '0, t1);
    if (t1 <= t0) report_failure("mtime low did not increase between two reads");
    run_beat(1'b0, 32'h3000_BFFC, '0, 4'hF, CTI_CLASSIC, 1'b0, '0, hi);

    // Compare point 50 ticks ahead, low half first
    cmp = {hi, t1} + 64'd50;
    run_beat(1'b1, 32'h3000_4000, cmp[31:0], 4'hF, CTI_CLASSIC, 1'b0, '0, rdata);
    run_beat(1'b1, 32'h3000_4004, cmp[63:32], 4'hF, CTI_CLASSIC, 1'b0, '0, rdata);
    check_irq("timer_irq_o", 1'b0, timer_irq_o);
    run_beat(1'b0, 32'h3000_4000, '0, 4'hF, CTI_CLASSIC, 1'b1, cmp[31:0], rdata);
    run_beat(1'b0, 32'h3000_1000, '0, 4'hF, CTI_CLASSIC, 1'b1, '0, rdata);
    wait_timer_irq(100);
    run_beat(1'b1, 32'h3000_4000, 32'hFFFF_FFFF, 4'hF, CTI_CLASSIC, 1'b0, '0, rdata);
    run_beat(1'b1, 32'h3000_4004, 32'hFFFF_FFFF, 4'hF, CTI_CLASSIC, 1'b0, '0, rdata);
    check_irq("timer_irq_o", 1'b0, timer_irq_o);

    // Let the compare process drain
    repeat (2) @(posedge clk_i);
    if (exp_err_q.size() != 0) begin
      report_failure("Some responses were never compared");
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

//--- compile.f
+incdir+include
src/fabric_pkg.sv
src/wb_req_decoder.sv
src/line_ram.sv
src/line_ram_adapter.sv
src/clint_timer.sv
src/wb_resp_mux.sv
src/wb_soc_fabric.sv
dv/tb_wb_soc_fabric.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the fabric testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f \
  --top-module tb_wb_soc_fabric -Mdir obj_dir

# The simulation exits non-zero on failure, so its status is caught here
sim_out=$(./obj_dir/Vtb_wb_soc_fabric 2>&1) || true
echo "$sim_out"

if echo "$sim_out" | grep -qx "TEST PASS"; then
  exit 0
else
  exit 1
fi
